// ==== hdl/cpuPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpuPkg
// widths, MIPS opcode and function codes,
// ALU and forwarding enums, stage payloads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpuPkg;

    localparam int dataW    = 32;
    localparam int regAddrW = 5;

    // major opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // R-type function field
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;

    typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

    typedef struct packed {
        logic [dataW-1:0] instr;
        logic [dataW-1:0] pc;
    } ifIdT;

    typedef struct packed {
        logic [dataW-1:0]    pc;
        logic [dataW-1:0]    rsData;
        logic [dataW-1:0]    rtData;
        logic [dataW-1:0]    imm;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] dst;
        aluOpT               aluOp;
        logic                useImm;
        logic                memRead;
        logic                memWrite;
        logic                regWrite;
        logic                isBranch;
    } idExT;

    typedef struct packed {
        logic [dataW-1:0]    aluResult;
        logic [dataW-1:0]    storeData;
        logic [regAddrW-1:0] dst;
        logic                memRead;
        logic                memWrite;
        logic                regWrite;
    } exMemT;

    typedef struct packed {
        logic [dataW-1:0]    aluResult;
        logic [dataW-1:0]    loadData;
        logic [regAddrW-1:0] dst;
        logic                memRead;
        logic                regWrite;
    } memWbT;

endpackage

// ==== hdl/hazardIf.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hazardIf
// stall, flush and forwarding signals
// between hazard unit and the stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface hazardIf (
    input logic clk,
    input logic rstN
);
    logic [cpuPkg::regAddrW-1:0] idRs, idRt;      // instruction in decode
    logic [cpuPkg::regAddrW-1:0] exRs, exRt;      // instruction in execute
    logic [cpuPkg::regAddrW-1:0] exDst;
    logic                        exMemRead;
    logic                        branchTaken;
    logic [cpuPkg::regAddrW-1:0] memDst, wbDst;
    logic                        memRegWrite, wbRegWrite;
    logic                        stallFront, flushIdEx, flushIfId;
    cpuPkg::fwdSelT              fwdA, fwdB;

    modport hazard (
        input  clk, rstN, idRs, idRt, exRs, exRt, exDst, exMemRead, branchTaken,
        input  memDst, memRegWrite, wbDst, wbRegWrite,
        output stallFront, flushIdEx, flushIfId, fwdA, fwdB
    );
    modport decode (output idRs, idRt);
    modport execute (output exRs, exRt, exDst, exMemRead, branchTaken, input fwdA, fwdB);
    modport core (
        output memDst, memRegWrite, wbDst, wbRegWrite,
        input  stallFront, flushIdEx, flushIfId, branchTaken
    );
endinterface

// ==== hdl/stageReg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stageReg
// pipeline register for any payload type,
// holds on stall, zeroes on clear
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    clear,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (clear) begin    // clear wins over stall
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    clearGivesBubble: assert property (@(posedge clk) disable iff (!rstN) clear |=> q == '0)
        else $error("stage register not cleared after clear");

endmodule

// ==== hdl/decodeStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decodeStage
// instruction decoder, 32-entry register
// file with write-before-read, immediates
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module decodeStage (
    input  logic                        clk,
    input  logic                        rstN,
    input  cpuPkg::ifIdT                ifId,
    input  logic [cpuPkg::regAddrW-1:0] wbAddr,
    input  logic [cpuPkg::dataW-1:0]    wbData,
    input  logic                        wbWe,
    hazardIf.decode                     hz,
    output cpuPkg::idExT                idEx
);
    logic [cpuPkg::dataW-1:0]    regs [32];
    logic [5:0]                  opcode, fn;
    logic [cpuPkg::regAddrW-1:0] rs, rt, rd;
    logic [15:0]                 imm16;
    logic [cpuPkg::dataW-1:0]    rsData, rtData;
    cpuPkg::idExT                ctl;
    logic                        legal;

    assign opcode = ifId.instr[31:26];
    assign rs     = ifId.instr[25:21];
    assign rt     = ifId.instr[20:16];
    assign rd     = ifId.instr[15:11];
    assign imm16  = ifId.instr[15:0];
    assign fn     = ifId.instr[5:0];

    assign hz.idRs = rs;
    assign hz.idRt = rt;

    always_ff @(posedge clk) begin
        if (wbWe && wbAddr != '0) regs[wbAddr] <= wbData;
    end

    // writeback result bypasses the array in the same cycle
    assign rsData = (rs == '0) ? '0 : (wbWe && wbAddr == rs) ? wbData : regs[rs];
    assign rtData = (rt == '0) ? '0 : (wbWe && wbAddr == rt) ? wbData : regs[rt];

    always_comb begin
        ctl        = '0;
        ctl.pc     = ifId.pc;
        ctl.rsData = rsData;
        ctl.rtData = rtData;
        ctl.rs     = rs;
        ctl.rt     = rt;
        ctl.imm    = {{16{imm16[15]}}, imm16};    // sign extended by default
        legal      = 1'b1;
        case (opcode)
            cpuPkg::opRtype: begin
                ctl.dst      = rd;
                ctl.regWrite = 1'b1;
                case (fn)
                    cpuPkg::fnAddu: ctl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSubu: ctl.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd:  ctl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:   ctl.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnSlt:  ctl.aluOp = cpuPkg::aluSlt;
                    default:        legal     = 1'b0;
                endcase
            end
            cpuPkg::opAddiu: begin
                ctl.dst      = rt;
                ctl.useImm   = 1'b1;
                ctl.regWrite = 1'b1;
            end
            cpuPkg::opOri: begin
                ctl.imm      = {16'h0, imm16};
                ctl.aluOp    = cpuPkg::aluOr;
                ctl.dst      = rt;
                ctl.useImm   = 1'b1;
                ctl.regWrite = 1'b1;
            end
            cpuPkg::opLui: begin
                ctl.imm      = {16'h0, imm16};
                ctl.aluOp    = cpuPkg::aluLui;
                ctl.dst      = rt;
                ctl.useImm   = 1'b1;
                ctl.regWrite = 1'b1;
            end
            cpuPkg::opLw: begin
                ctl.dst      = rt;
                ctl.useImm   = 1'b1;
                ctl.memRead  = 1'b1;
                ctl.regWrite = 1'b1;
            end
            cpuPkg::opSw: begin
                ctl.useImm   = 1'b1;
                ctl.memWrite = 1'b1;
            end
            cpuPkg::opBeq:   ctl.isBranch = 1'b1;    // compare done in execute
            default:         legal        = 1'b0;
        endcase
        idEx = legal ? ctl : '0;
    end

    // a write aimed at r0 must not leak through the bypass
    zeroRegStaysZero: assert property (@(posedge clk) disable iff (!rstN)
        (wbWe && wbAddr == '0) |-> ((rs != '0 || rsData == '0) && (rt != '0 || rtData == '0)))
        else $error("register 0 read as nonzero");

endmodule

// ==== hdl/executeStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// executeStage
// operand forwarding, ALU, beq compare
// and branch target
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module executeStage (
    input  cpuPkg::idExT             idEx,
    input  logic [cpuPkg::dataW-1:0] exMemFwd,
    input  logic [cpuPkg::dataW-1:0] wbFwd,
    hazardIf.execute                 hz,
    output cpuPkg::exMemT            exMem,
    output logic [cpuPkg::dataW-1:0] branchTarget
);
    logic [cpuPkg::dataW-1:0] opA, opB, aluB, aluResult;

    assign hz.exRs      = idEx.rs;
    assign hz.exRt      = idEx.rt;
    assign hz.exDst     = idEx.dst;
    assign hz.exMemRead = idEx.memRead;

    always_comb begin
        case (hz.fwdA)
            cpuPkg::fwdMem: opA = exMemFwd;
            cpuPkg::fwdWb:  opA = wbFwd;
            default:        opA = idEx.rsData;
        endcase
        case (hz.fwdB)
            cpuPkg::fwdMem: opB = exMemFwd;
            cpuPkg::fwdWb:  opB = wbFwd;
            default:        opB = idEx.rtData;
        endcase
    end

    assign aluB = idEx.useImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.aluOp)
            cpuPkg::aluSub: aluResult = opA - aluB;
            cpuPkg::aluAnd: aluResult = opA & aluB;
            cpuPkg::aluOr:  aluResult = opA | aluB;
            cpuPkg::aluSlt: aluResult = {{(cpuPkg::dataW-1){1'b0}}, $signed(opA) < $signed(aluB)};
            cpuPkg::aluLui: aluResult = {aluB[15:0], 16'h0};
            default:        aluResult = opA + aluB;
        endcase
    end

    // beq compares the forwarded values, not the stale register reads
    assign hz.branchTaken = idEx.isBranch && (opA == opB);
    assign branchTarget   = idEx.pc + cpuPkg::dataW'(4) + {idEx.imm[cpuPkg::dataW-3:0], 2'b00};

    always_comb begin
        exMem.aluResult = aluResult;
        exMem.storeData = opB;    // sw data is rt
        exMem.dst       = idEx.dst;
        exMem.memRead   = idEx.memRead;
        exMem.memWrite  = idEx.memWrite;
        exMem.regWrite  = idEx.regWrite;
    end

endmodule

// ==== hdl/hazardUnit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hazardUnit
// load-use stall, branch flush and
// forwarding selection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module hazardUnit (
    hazardIf.hazard hz
);
    logic loadUse;

    // memory stage is younger, so it wins over writeback
    function automatic cpuPkg::fwdSelT pickFwd(input logic [cpuPkg::regAddrW-1:0] src);
        if (src != '0 && hz.memRegWrite && hz.memDst == src) begin
            return cpuPkg::fwdMem;
        end
        if (src != '0 && hz.wbRegWrite && hz.wbDst == src) begin
            return cpuPkg::fwdWb;
        end
        return cpuPkg::fwdReg;
    endfunction

    assign loadUse = hz.exMemRead && hz.exDst != '0
                     && (hz.exDst == hz.idRs || hz.exDst == hz.idRt);

    assign hz.stallFront = loadUse;                  // hold pc and IF/ID
    assign hz.flushIdEx  = loadUse || hz.branchTaken;
    assign hz.flushIfId  = hz.branchTaken;

    assign hz.fwdA = pickFwd(hz.exRs);
    assign hz.fwdB = pickFwd(hz.exRt);

    noFwdFromZero: assert property (@(posedge hz.clk) disable iff (!hz.rstN)
        (hz.fwdA != cpuPkg::fwdReg)
            |-> (((hz.fwdA == cpuPkg::fwdMem) ? hz.memDst : hz.wbDst) != '0))
        else $error("operand A forwarded from register 0");

endmodule

// ==== hdl/cpuCore.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpuCore
// five-stage MIPS subset pipeline:
// pc, stage registers, memory ports,
// writeback select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpuCore (
    input  logic                     clk,
    input  logic                     rstN,
    output logic [cpuPkg::dataW-1:0] instrAddr,
    input  logic [cpuPkg::dataW-1:0] instrData,
    output logic [cpuPkg::dataW-1:0] dataAddr,
    output logic [cpuPkg::dataW-1:0] dataWrData,
    output logic                     dataWe,
    output logic                     dataRe,
    input  logic [cpuPkg::dataW-1:0] dataRdData
);
    logic [cpuPkg::dataW-1:0] pc, branchTarget, wbData;
    cpuPkg::ifIdT             ifIdD, ifIdQ;
    cpuPkg::idExT             idExD, idExQ;
    cpuPkg::exMemT            exMemD, exMemQ;
    cpuPkg::memWbT            memWbD, memWbQ;

    hazardIf hz (.clk(clk), .rstN(rstN));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (hz.branchTaken) begin    // branch beats load-use stall
            pc <= branchTarget;
        end else if (!hz.stallFront) begin
            pc <= pc + cpuPkg::dataW'(4);
        end
    end

    assign instrAddr = pc;
    assign ifIdD     = '{instr: instrData, pc: pc};

    stageReg #(.payloadT(cpuPkg::ifIdT)) ifIdReg_i (
        .clk(clk), .rstN(rstN), .stall(hz.stallFront), .clear(hz.flushIfId),
        .d(ifIdD), .q(ifIdQ)
    );

    decodeStage decodeStage_i (
        .clk(clk), .rstN(rstN), .ifId(ifIdQ),
        .wbAddr(memWbQ.dst), .wbData(wbData), .wbWe(memWbQ.regWrite),
        .hz(hz.decode), .idEx(idExD)
    );

    stageReg #(.payloadT(cpuPkg::idExT)) idExReg_i (
        .clk(clk), .rstN(rstN), .stall(1'b0), .clear(hz.flushIdEx),
        .d(idExD), .q(idExQ)
    );

    executeStage executeStage_i (
        .idEx(idExQ), .exMemFwd(exMemQ.aluResult), .wbFwd(wbData),
        .hz(hz.execute), .exMem(exMemD), .branchTarget(branchTarget)
    );

    stageReg #(.payloadT(cpuPkg::exMemT)) exMemReg_i (
        .clk(clk), .rstN(rstN), .stall(1'b0), .clear(1'b0),
        .d(exMemD), .q(exMemQ)
    );

    // memory stage talks straight to the data port
    assign dataAddr   = exMemQ.aluResult;
    assign dataWrData = exMemQ.storeData;
    assign dataWe     = exMemQ.memWrite;
    assign dataRe     = exMemQ.memRead;

    assign memWbD = '{aluResult: exMemQ.aluResult, loadData: dataRdData, dst: exMemQ.dst,
                      memRead: exMemQ.memRead, regWrite: exMemQ.regWrite};

    stageReg #(.payloadT(cpuPkg::memWbT)) memWbReg_i (
        .clk(clk), .rstN(rstN), .stall(1'b0), .clear(1'b0),
        .d(memWbD), .q(memWbQ)
    );

    assign wbData = memWbQ.memRead ? memWbQ.loadData : memWbQ.aluResult;

    assign hz.memDst      = exMemQ.dst;
    assign hz.memRegWrite = exMemQ.regWrite;
    assign hz.wbDst       = memWbQ.dst;
    assign hz.wbRegWrite  = memWbQ.regWrite;

    hazardUnit hazardUnit_i (.hz(hz.hazard));

endmodule

// ==== tb/cpuCoreTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpuCoreTb
// clock, reset, instruction and data
// memory models, program table with
// expected stores, checks and timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpuCoreTb;
    localparam int nTests = 8;

    logic                     clk = 1'b0;
    logic                     rstN;
    logic [cpuPkg::dataW-1:0] instrAddr, instrData, dataAddr, dataWrData, dataRdData;
    logic                     dataWe, dataRe;

    logic [31:0] imem [16];
    logic [31:0] dmem [16];

    string       names [nTests];
    logic [31:0] progs [nTests][8];    // unused words are nop (zero)
    int          nStores [nTests];
    logic [31:0] expAddr [nTests][4];
    logic [31:0] expData [nTests][4];
    logic [31:0] gotAddr [4];
    logic [31:0] gotData [4];

    int cycles = 0;
    int limit  = 0;
    int passed = 0;
    int failed = 0;
    int errors = 0;

    cpuCore cpuCore_i (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
        .dataAddr(dataAddr), .dataWrData(dataWrData), .dataWe(dataWe), .dataRe(dataRe),
        .dataRdData(dataRdData)
    );

    always #20 clk = ~clk;

    assign instrData  = (instrAddr[31:6] == '0) ? imem[instrAddr[5:2]] : '0;
    assign dataRdData = dataRe ? dmem[dataAddr[5:2]] : '0;

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) dmem[i] <= '0;
        end else if (dataWe) begin
            dmem[dataAddr[5:2]] <= dataWrData;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run stopped after %0d cycles, expected stores never arrived", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input logic [5:0] fn);
        return {cpuPkg::opRtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rs, input int rt,
                                          input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] sext(input int v);
        return {{16{v[15]}}, v[15:0]};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic buildTable();
        logic [31:0] rng;
        int          imm [4];
        logic [31:0] r1, r2, r3, r4;
        rng = 32'd30717;
        for (int k = 0; k < 4; k++) begin
            rng    = xorshift(rng);
            imm[k] = int'(rng[15:0]);
        end

        names[0]   = "immOps";
        nStores[0] = 4;
        progs[0]   = '{iType(cpuPkg::opOri, 0, 1, 'h1234), iType(cpuPkg::opLui, 0, 2, 'habcd),
                       iType(cpuPkg::opAddiu, 1, 3, -4), iType(cpuPkg::opAddiu, 2, 4, 'h8000),
                       iType(cpuPkg::opSw, 0, 1, 0), iType(cpuPkg::opSw, 0, 2, 4),
                       iType(cpuPkg::opSw, 0, 3, 8), iType(cpuPkg::opSw, 0, 4, 12)};
        expAddr[0] = '{0, 4, 8, 12};
        expData[0] = '{'h1234, 'habcd0000, 'h1230, 'habcc8000};    // 8000 sign-extends

        names[1]   = "addSubSlt";
        nStores[1] = 3;
        progs[1]   = '{iType(cpuPkg::opOri, 0, 1, 'hf7), iType(cpuPkg::opAddiu, 0, 2, -16),
                       rType(1, 2, 3, cpuPkg::fnAddu), rType(1, 2, 4, cpuPkg::fnSubu),
                       rType(2, 1, 5, cpuPkg::fnSlt), iType(cpuPkg::opSw, 0, 3, 0),
                       iType(cpuPkg::opSw, 0, 4, 4), iType(cpuPkg::opSw, 0, 5, 8)};
        expAddr[1] = '{0, 4, 8, 0};
        expData[1] = '{'he7, 'h107, 1, 0};    // -16 < 247 signed

        names[2]   = "logicSlt";
        nStores[2] = 3;
        progs[2]   = '{iType(cpuPkg::opOri, 0, 1, 'hf7), iType(cpuPkg::opAddiu, 0, 2, -16),
                       rType(1, 2, 3, cpuPkg::fnAnd), rType(1, 2, 4, cpuPkg::fnOr),
                       rType(1, 2, 5, cpuPkg::fnSlt), iType(cpuPkg::opSw, 0, 3, 0),
                       iType(cpuPkg::opSw, 0, 4, 4), iType(cpuPkg::opSw, 0, 5, 8)};
        expAddr[2] = '{0, 4, 8, 0};
        expData[2] = '{'hf0, 'hfffffff7, 0, 0};

        // distance one from memory stage, distance two from writeback
        names[3]   = "forward";
        nStores[3] = 3;
        progs[3]   = '{iType(cpuPkg::opOri, 0, 1, 5), rType(1, 1, 2, cpuPkg::fnAddu),
                       rType(2, 1, 3, cpuPkg::fnAddu), rType(3, 1, 4, cpuPkg::fnSubu),
                       iType(cpuPkg::opSw, 0, 2, 0), iType(cpuPkg::opSw, 0, 3, 4),
                       iType(cpuPkg::opSw, 0, 4, 8), 0};
        expAddr[3] = '{0, 4, 8, 0};
        expData[3] = '{10, 15, 10, 0};

        names[4]   = "loadUse";
        nStores[4] = 3;
        progs[4]   = '{iType(cpuPkg::opOri, 0, 1, 'h55), iType(cpuPkg::opSw, 0, 1, 16),
                       iType(cpuPkg::opLw, 0, 2, 16), iType(cpuPkg::opAddiu, 2, 3, 3),
                       iType(cpuPkg::opSw, 0, 3, 20), iType(cpuPkg::opSw, 0, 2, 24), 0, 0};
        expAddr[4] = '{16, 20, 24, 0};
        expData[4] = '{'h55, 'h58, 'h55, 0};

        // taken beq skips two zero stores and the second beq falls through
        names[5]   = "branch";
        nStores[5] = 2;
        progs[5]   = '{iType(cpuPkg::opOri, 0, 1, 9), iType(cpuPkg::opOri, 0, 2, 9),
                       iType(cpuPkg::opBeq, 1, 2, 2), iType(cpuPkg::opSw, 0, 0, 0),
                       iType(cpuPkg::opSw, 0, 0, 4), iType(cpuPkg::opBeq, 1, 0, 1),
                       iType(cpuPkg::opSw, 0, 2, 8), iType(cpuPkg::opSw, 0, 1, 12)};
        expAddr[5] = '{8, 12, 0, 0};
        expData[5] = '{9, 9, 0, 0};

        r1 = sext(imm[0]);
        r2 = r1 + sext(imm[1]);
        r3 = r2 | {16'h0, imm[2][15:0]};    // ori zero-extends
        r4 = r3 + sext(imm[3]);
        names[6]   = "randomImm";
        nStores[6] = 4;
        progs[6]   = '{iType(cpuPkg::opAddiu, 0, 1, imm[0]), iType(cpuPkg::opAddiu, 1, 2, imm[1]),
                       iType(cpuPkg::opOri, 2, 3, imm[2]), iType(cpuPkg::opAddiu, 3, 4, imm[3]),
                       iType(cpuPkg::opSw, 0, 1, 0), iType(cpuPkg::opSw, 0, 2, 4),
                       iType(cpuPkg::opSw, 0, 3, 8), iType(cpuPkg::opSw, 0, 4, 12)};
        expAddr[6] = '{0, 4, 8, 12};
        expData[6] = '{r1, r2, r3, r4};

        names[7]   = "regZero";
        nStores[7] = 2;
        progs[7]   = '{iType(cpuPkg::opAddiu, 0, 0, 'h77), rType(0, 0, 1, cpuPkg::fnAddu),
                       iType(cpuPkg::opOri, 0, 0, 5), iType(cpuPkg::opSw, 0, 1, 0),
                       iType(cpuPkg::opSw, 0, 0, 4), 0, 0, 0};
        expAddr[7] = '{0, 4, 0, 0};
        expData[7] = '{0, 0, 0, 0};

        // 16 reset cycles and 20 spare per test plus three per instruction
        for (int t = 0; t < nTests; t++) begin
            limit += 36;
            for (int k = 0; k < 8; k++) begin
                if (progs[t][k] != '0) limit += 3;
            end
        end
    endtask

    task automatic runTest(input int t);
        int seen;
        int reads;
        int expReads;
        bit ok;
        seen     = 0;
        reads    = 0;
        expReads = 0;
        ok       = 1'b1;
        rstN     = 1'b0;
        for (int k = 0; k < 16; k++) imem[k] = '0;
        for (int k = 0; k < 8; k++) begin
            imem[k] = progs[t][k];
            if (progs[t][k][31:26] == cpuPkg::opLw) expReads++;    // one data read per load
        end
        repeat (16) @(negedge clk);
        assert (instrAddr == '0 && !dataWe && !dataRe) else begin
            $display("[ERROR] %s reset: expected pc 0 we 0 re 0, actual pc %h we %b re %b",
                     names[t], instrAddr, dataWe, dataRe);
            ok = 1'b0;
            errors++;
        end
        rstN = 1'b1;
        while (seen < nStores[t]) begin
            @(negedge clk);    // store outputs are stable mid-cycle
            if (dataRe) reads++;
            if (dataWe) begin
                gotAddr[seen] = dataAddr;
                gotData[seen] = dataWrData;
                seen++;
            end
        end
        for (int k = 0; k < nStores[t]; k++) begin
            assert (gotAddr[k] == expAddr[t][k] && gotData[k] == expData[t][k]) else begin
                $display("[ERROR] %s store %0d: expected %h at %h, actual %h at %h", names[t],
                         k, expData[t][k], expAddr[t][k], gotData[k], gotAddr[k]);
                ok = 1'b0;
                errors++;
            end
        end
        assert (reads == expReads) else begin
            $display("[ERROR] %s data reads: expected %0d, actual %0d", names[t],
                     expReads, reads);
            ok = 1'b0;
            errors++;
        end
        if (ok) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %-10s %0d stores, %s", names[t], nStores[t], ok ? "ok" : "mismatch");
    endtask

    initial begin
        rstN = 1'b0;
        buildTable();
        for (int t = 0; t < nTests; t++) begin
            runTest(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d wrong values",
                 nTests, passed, failed, errors);
        if (failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/cpuPkg.sv
hdl/hazardIf.sv
hdl/stageReg.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/hazardUnit.sv
hdl/cpuCore.sv
tb/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build the cpuCore testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cpuCoreTb -o cpuCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/cpuCoreSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
